//--- tb.f
design/peek_pkg.sv
design/enable_div.sv
design/hex_display.sv
design/fill_engine.sv
design/mem_arbiter.sv
design/word_mem.sv
design/peek_unit.sv
design/debug_top.sv
verif/debug_props.sv
verif/debug_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = debug_tb
FILELIST = tb.f
OBJ_DIR  = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# The simulation binary exits with a failing status when the testbench stops on $fatal.
sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- verif/debug_tb.sv
`default_nettype none

module debug_tb
    import peek_pkg::*;
();

    localparam int CLK_PERIOD      = 40;
    localparam int DRIVE_DELAY     = 5;
    localparam int RESET_CYCLES    = 4;
    localparam int NUM_TESTS       = 6;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * (FILL_WORDS + 4 * DIV_CNT) + 200;
    localparam int PEEKS_PER_FILL  = 8;

    // Active-low segment codes for the digits 0 to F with segment g in bit 6.
    localparam logic [6:0] SEG_TABLE [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
    };

    logic               clk;
    logic               rst_n;
    logic [ADDR_W-1:0]  sw;
    logic [3:0]         key;
    logic [5:0][6:0]    hex;
    logic [WORD_W-1:0]  peek_data;
    logic               fill_busy;

    logic               key_q;
    logic               model_busy;
    logic [COUNT_W-1:0] model_count;
    logic [COUNT_W-1:0] count_q;
    logic [1:0]         sel_q;
    logic [WORD_W-1:0]  side_expect;
    logic [31:0]        lcg_state;

    debug_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .sw        (sw),
        .key       (key),
        .hex       (hex),
        .peek_data (peek_data),
        .fill_busy (fill_busy)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // The base sits in the upper half of the word and the address in the lower half.
    function automatic logic [WORD_W-1:0] pattern_word(input logic [ADDR_W-1:0] base,
                                                      input logic [ADDR_W-1:0] addr);
        return WORD_W'({base, 16'(addr)});
    endfunction

    function automatic logic [41:0] display_code(input logic [WORD_W-1:0] word);
        logic [5:0][6:0] code;
        for (int i = 0; i < 6; i++)
            code[i] = SEG_TABLE[word[4*i +: 4]];
        return code;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped on a failed check");
    endtask

    task automatic report_mismatch(input string test_name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        stop_with_failure($sformatf("[FAIL] %s: expected 0x%0h, actual 0x%0h",
                                    test_name, expected, actual));
    endtask

    task automatic check_value(input string test_name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected)
        else
            report_mismatch(test_name, expected, actual);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // Presses key 0 with the base on the switches and follows the fill until it ends.
    task automatic run_fill(input logic [ADDR_W-1:0] base, input logic check_hold,
                            input logic [WORD_W-1:0] held_word);
        int cycles;
        sw     = base;
        key[0] = 1'b0;
        wait_cycles(1);
        check_value("fill start", 64'(1'b1), 64'(fill_busy));
        cycles = 0;
        while (fill_busy)
        begin
            // A second press halfway through must not stretch the fill.
            key[0] = (cycles != FILL_WORDS / 2);
            if (check_hold)
                check_value("priority hold", 64'(held_word), 64'(peek_data));
            cycles++;
            wait_cycles(1);
        end
        key[0] = 1'b1;
        check_value("fill length", 64'(FILL_WORDS), 64'(cycles));
    endtask

    task automatic peek_memory(input logic [ADDR_W-1:0] base, input logic [ADDR_W-1:0] addr);
        sw = addr;
        wait_cycles(2);
        check_value("memory peek", 64'(pattern_word(base, addr)), 64'(peek_data));
    endtask

    task automatic check_display(input logic [WORD_W-1:0] word);
        wait_cycles(DIV_CNT);
        check_value("display", 64'(display_code(word)), 64'(hex));
    endtask

    // Reference for the fill timing and the delayed count and id seen by the peek path.
    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            key_q       <= 1'b1;
            model_busy  <= 1'b0;
            model_count <= '0;
            count_q     <= '0;
            sel_q       <= PEEK_MEM;
        end
        else
        begin
            key_q   <= key[0];
            count_q <= model_count;
            sel_q   <= ~key[2:1];
            if (model_busy)
            begin
                model_count <= model_count + 1'b1;
                model_busy  <= (model_count != COUNT_W'(FILL_WORDS - 1));
            end
            else if (key_q && !key[0])
            begin
                model_busy  <= 1'b1;
                model_count <= '0;
            end
        end
    end

    assign side_expect = (sel_q == PEEK_COUNT) ? WORD_W'(count_q) : '0;

    busy_matches: assert property (@(posedge clk) disable iff (!rst_n)
        fill_busy == model_busy)
    else
        report_mismatch("fill busy", 64'($sampled(model_busy)), 64'($sampled(fill_busy)));

    side_peek_matches: assert property (@(posedge clk) disable iff (!rst_n)
        (sel_q != PEEK_MEM) |-> (peek_data == side_expect))
    else
        report_mismatch("count peek", 64'($sampled(side_expect)), 64'($sampled(peek_data)));

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_with_failure("Timeout: the tests did not finish within the watchdog limit");
    end

    initial
    begin
        logic [ADDR_W-1:0] base_a;
        logic [ADDR_W-1:0] base_b;
        logic [ADDR_W-1:0] addr;
        clk       = 1'b0;
        rst_n     = 1'b0;
        sw        = '0;
        key       = 4'hF;
        lcg_state = 32'd55323;
        addr      = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        check_value("reset busy", 64'(1'b0), 64'(fill_busy));
        check_value("reset peek", 64'(0), 64'(peek_data));
        check_value("reset display", 64'({6{SEG_BLANK}}), 64'(hex));

        // First fill with the count selected, so it is watched while it climbs.
        key[2:1]  = 2'b10;
        lcg_state = lcg_next(lcg_state);
        base_a    = lcg_state[25:16];
        run_fill(base_a, 1'b0, '0);
        wait_cycles(1);
        check_value("count peek", 64'(FILL_WORDS), 64'(peek_data));
        key[2:1] = 2'b01;
        wait_cycles(1);
        check_value("id 2 peek", 64'(0), 64'(peek_data));
        key[2:1] = 2'b00;
        wait_cycles(1);
        check_value("id 3 peek", 64'(0), 64'(peek_data));

        key[2:1] = 2'b11;
        for (int i = 0; i < PEEKS_PER_FILL; i++)
        begin
            lcg_state = lcg_next(lcg_state);
            addr      = ADDR_W'(lcg_state[21:16]);
            peek_memory(base_a, addr);
        end
        check_display(pattern_word(base_a, addr));

        // The second base doubles as the held peek address, so it stays inside the fill.
        lcg_state = lcg_next(lcg_state);
        base_b    = ADDR_W'(lcg_state[21:16]);
        if (base_b == base_a)
            base_b = base_b ^ 10'd1;
        peek_memory(base_a, base_b);
        run_fill(base_b, 1'b1, pattern_word(base_a, base_b));
        check_value("priority hold", 64'(pattern_word(base_a, base_b)), 64'(peek_data));
        wait_cycles(1);
        check_value("priority hold", 64'(pattern_word(base_a, base_b)), 64'(peek_data));
        wait_cycles(1);
        check_value("priority update", 64'(pattern_word(base_b, base_b)), 64'(peek_data));

        for (int i = 0; i < PEEKS_PER_FILL; i++)
        begin
            lcg_state = lcg_next(lcg_state);
            addr      = ADDR_W'(lcg_state[21:16]);
            peek_memory(base_b, addr);
        end
        check_display(pattern_word(base_b, addr));

        if (DUT.u_arb.arb_props.failed || DUT.u_display.disp_props.failed)
            stop_with_failure("A protocol assertion on the arbiter or the display failed");
        else
        begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- verif/debug_props.sv
`default_nettype none

module debug_props
(
    input logic            clk,
    input logic            rst_n,
    input logic            grant_fill,
    input logic            grant_peek,
    input logic            read_valid,
    input logic            refresh,
    input logic [5:0][6:0] hex
);

    logic failed = 1'b0;

    one_grant: assert property (@(posedge clk) disable iff (!rst_n)
        !(grant_fill && grant_peek))
    else
    begin
        failed = 1'b1;
        $error("Fill and peek were granted in the same cycle");
    end

    // Read data is marked only for a read that was granted one cycle before.
    valid_after_grant: assert property (@(posedge clk) disable iff (!rst_n)
        read_valid |-> $past(grant_peek))
    else
    begin
        failed = 1'b1;
        $error("read_valid without a peek grant in the previous cycle");
    end

    hex_on_refresh: assert property (@(posedge clk) disable iff (!rst_n)
        !$stable(hex) |-> $past(refresh))
    else
    begin
        failed = 1'b1;
        $error("Display digits changed without a refresh strobe");
    end

endmodule

// The arbiter has no digits and the display has no grants, so those inputs are tied off.
bind mem_arbiter debug_props arb_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .grant_fill (grant_fill),
    .grant_peek (grant_peek),
    .read_valid (read_valid),
    .refresh    (1'b0),
    .hex        ('0)
);

bind hex_display debug_props disp_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .grant_fill (1'b0),
    .grant_peek (1'b0),
    .read_valid (1'b0),
    .refresh    (refresh),
    .hex        (hex)
);

`default_nettype wire

//--- design/debug_top.sv
`default_nettype none

module debug_top
    import peek_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [9:0]        sw,
    input  logic [3:0]        key,
    output logic [5:0][6:0]   hex,
    output logic [WORD_W-1:0] peek_data,
    output logic              fill_busy
);

    peek_sel_t          sel;
    mem_req_t           fill_req;
    mem_req_t           peek_req;
    mem_req_t           mem_req;
    logic               grant_fill;
    logic               grant_peek;
    logic               read_valid;
    logic [WORD_W-1:0]  rdata;
    logic [COUNT_W-1:0] fill_count;
    logic               refresh;

    // Keys are active low, so a pressed key selects a set id bit.
    assign sel.id   = ~key[2:1];
    assign sel.addr = sw;

    enable_div u_div (
        .clk     (clk),
        .rst_n   (rst_n),
        .refresh (refresh)
    );

    hex_display u_display (
        .clk     (clk),
        .rst_n   (rst_n),
        .refresh (refresh),
        .value   (peek_data[23:0]),
        .hex     (hex)
    );

    fill_engine u_fill (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_n    (key[0]),
        .base       (sw),
        .grant      (grant_fill),
        .fill_req   (fill_req),
        .fill_busy  (fill_busy),
        .fill_count (fill_count)
    );

    mem_arbiter u_arb (
        .clk        (clk),
        .rst_n      (rst_n),
        .fill_req   (fill_req),
        .peek_req   (peek_req),
        .grant_fill (grant_fill),
        .grant_peek (grant_peek),
        .mem_req    (mem_req),
        .read_valid (read_valid)
    );

    word_mem u_mem (
        .clk     (clk),
        .mem_req (mem_req),
        .rdata   (rdata)
    );

    peek_unit u_peek (
        .clk        (clk),
        .rst_n      (rst_n),
        .sel        (sel),
        .fill_count (fill_count),
        .peek_req   (peek_req),
        .grant      (grant_peek),
        .read_valid (read_valid),
        .rdata      (rdata),
        .peek_data  (peek_data)
    );

endmodule

`default_nettype wire

//--- design/peek_unit.sv
`default_nettype none

module peek_unit
    import peek_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  peek_sel_t          sel,
    input  logic [COUNT_W-1:0] fill_count,
    output mem_req_t           peek_req,
    input  logic               grant,
    input  logic               read_valid,
    input  logic [WORD_W-1:0]  rdata,
    output logic [WORD_W-1:0]  peek_data
);

    logic [1:0] id_q;
    logic       use_word;

    // A read of the switch address is asked for on every cycle.
    always_comb
    begin
        peek_req.req   = 1'b1;
        peek_req.we    = 1'b0;
        peek_req.addr  = sel.addr;
        peek_req.wdata = '0;
    end

    // The id travels with the read so a word is only taken for a memory peek.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            id_q <= PEEK_MEM;
        else if (grant)
            id_q <= sel.id;
    end

    assign use_word = read_valid && (id_q == PEEK_MEM);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            peek_data <= '0;
        else
        begin
            case (sel.id)
                PEEK_MEM:
                begin
                    // Starved reads during a fill leave the last word in place.
                    if (use_word)
                        peek_data <= rdata;
                end
                PEEK_COUNT:
                    peek_data <= WORD_W'(fill_count);
                default:
                    peek_data <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/word_mem.sv
`default_nettype none

module word_mem
    import peek_pkg::*;
(
    input  logic              clk,
    input  mem_req_t          mem_req,
    output logic [WORD_W-1:0] rdata
);

    logic [WORD_W-1:0] mem [MEM_WORDS];

    // Single port, so a cycle either writes or reads.
    always_ff @(posedge clk)
    begin
        if (mem_req.req)
        begin
            if (mem_req.we)
                mem[mem_req.addr] <= mem_req.wdata;
            else
                rdata <= mem[mem_req.addr];
        end
    end

endmodule

`default_nettype wire

//--- design/mem_arbiter.sv
`default_nettype none

module mem_arbiter
    import peek_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  mem_req_t fill_req,
    input  mem_req_t peek_req,
    output logic     grant_fill,
    output logic     grant_peek,
    output mem_req_t mem_req,
    output logic     read_valid
);

    logic rd_pend;

    // The fill engine always wins and the peek reader gets the idle cycles.
    assign grant_fill = fill_req.req;
    assign grant_peek = peek_req.req & ~fill_req.req;

    // Without a fill the peek request passes through, and its own req says whether it is live.
    always_comb
    begin
        if (grant_fill)
            mem_req = fill_req;
        else
            mem_req = peek_req;
    end

    // Marks the word that the memory returns for a granted peek read.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            rd_pend <= 1'b0;
        else
            rd_pend <= grant_peek & ~peek_req.we;
    end

    assign read_valid = rd_pend;

endmodule

`default_nettype wire

//--- design/fill_engine.sv
`default_nettype none

module fill_engine
    import peek_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start_n,
    input  logic [ADDR_W-1:0]  base,
    input  logic               grant,
    output mem_req_t           fill_req,
    output logic               fill_busy,
    output logic [COUNT_W-1:0] fill_count
);

    logic              start_q;
    logic              launch;
    logic [ADDR_W-1:0] base_q;
    logic [ADDR_W-1:0] wr_addr;

    // A press is a high-to-low step of the key while no fill runs.
    assign launch = start_q & ~start_n & ~fill_busy;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            start_q    <= 1'b1;
            fill_busy  <= 1'b0;
            fill_count <= '0;
        end
        else
        begin
            start_q <= start_n;
            if (launch)
            begin
                fill_busy  <= 1'b1;
                fill_count <= '0;
            end
            else if (fill_busy && grant)
            begin
                fill_count <= fill_count + 1'b1;
                if (fill_count == COUNT_W'(FILL_WORDS - 1))
                    fill_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (launch)
            base_q <= base;
    end

    // The word count doubles as the write address.
    assign wr_addr = ADDR_W'(fill_count);

    always_comb
    begin
        fill_req.req   = fill_busy;
        fill_req.we    = 1'b1;
        fill_req.addr  = wr_addr;
        fill_req.wdata = (WORD_W'(base_q) << 16) + WORD_W'(wr_addr);
    end

endmodule

`default_nettype wire

//--- design/hex_display.sv
`default_nettype none

module hex_display
    import peek_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             refresh,
    input  logic [23:0]      value,
    output logic [5:0][6:0]  hex
);

    logic [23:0] disp_q;
    logic        shown;

    // Active-low segments with segment g in bit 6.
    function automatic logic [6:0] seg7(input logic [3:0] nib);
        logic [6:0] s;
        case (nib)
            4'h0: s = 7'b1000000;
            4'h1: s = 7'b1111001;
            4'h2: s = 7'b0100100;
            4'h3: s = 7'b0110000;
            4'h4: s = 7'b0011001;
            4'h5: s = 7'b0010010;
            4'h6: s = 7'b0000010;
            4'h7: s = 7'b1111000;
            4'h8: s = 7'b0000000;
            4'h9: s = 7'b0010000;
            4'hA: s = 7'b0001000;
            4'hB: s = 7'b0000011;
            4'hC: s = 7'b1000110;
            4'hD: s = 7'b0100001;
            4'hE: s = 7'b0000110;
            default: s = 7'b0001110;
        endcase
        return s;
    endfunction

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            disp_q <= '0;
            shown  <= 1'b0;
        end
        else if (refresh)
        begin
            disp_q <= value;
            shown  <= 1'b1;
        end
    end

    // Digits stay dark until the first strobe has loaded a value.
    always_comb
    begin
        for (int i = 0; i < 6; i++)
        begin
            hex[i] = shown ? seg7(disp_q[4*i +: 4]) : SEG_BLANK;
        end
    end

endmodule

`default_nettype wire

//--- design/enable_div.sv
`default_nettype none

module enable_div
    import peek_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    output logic refresh
);

    logic [DIV_W-1:0] cnt;

    // The strobe is registered, so it lands one cycle after the wrap value is seen.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cnt     <= '0;
            refresh <= 1'b0;
        end
        else if (cnt == DIV_W'(DIV_CNT - 1))
        begin
            cnt     <= '0;
            refresh <= 1'b1;
        end
        else
        begin
            cnt     <= cnt + 1'b1;
            refresh <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- design/peek_pkg.sv
`default_nettype none

package peek_pkg;

    localparam int WORD_W     = 32;
    localparam int ADDR_W     = 10;
    localparam int MEM_WORDS  = 1024;
    localparam int FILL_WORDS = 64;
    localparam int COUNT_W    = $clog2(FILL_WORDS + 1);
    localparam int DIV_CNT    = 50;
    localparam int DIV_W      = $clog2(DIV_CNT);

    localparam logic [1:0] PEEK_MEM   = 2'd0;
    localparam logic [1:0] PEEK_COUNT = 2'd1;

    localparam logic [6:0] SEG_BLANK = 7'h7F;

    // One request on the shared memory port.
    typedef struct packed {
        logic              req;
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] wdata;
    } mem_req_t;

    // Peek source and address as set on the board keys and switches.
    typedef struct packed {
        logic [1:0]        id;
        logic [ADDR_W-1:0] addr;
    } peek_sel_t;

endpackage

`default_nettype wire
